// ==== common/noc_pkg.sv ====
/* Mesh geometry, port indices, credit width and the flit layout of the ALU tile network */
package noc_pkg;

    localparam int mesh_dim = 3;
    localparam int data_w = 64;
    // Tag space also bounds the number of requests in flight
    localparam int tag_w = 3;
    // Credit counters hold any fifo_depth up to 15
    localparam int cred_w = 4;

    typedef logic [1:0] coord_t;

    typedef enum logic [2:0] {
        dir_north = 3'd0,
        dir_east  = 3'd1,
        dir_south = 3'd2,
        dir_west  = 3'd3,
        dir_local = 3'd4
    } dir_e;

    // --------------------
    // Flit layout

    typedef struct packed {
        logic [3:0]       rsvd;
        logic             resp;
        logic [tag_w-1:0] tag;
        coord_t           dst_x;
        coord_t           dst_y;
        logic [3:0]       op;
    } flit_hdr_t;

    // Requests carry two operands, responses a result in the upper half
    typedef union packed {
        struct packed {
            logic [data_w-1:0] a;
            logic [data_w-1:0] b;
        } opnd;
        struct packed {
            logic [data_w-1:0] result;
            logic [data_w-1:0] unused;
        } res;
    } flit_payload_u;

    typedef struct packed {
        flit_hdr_t     hdr;
        flit_payload_u pl;
    } flit_t;

endpackage

// ==== common/alu_pkg.sv ====
/* ALU operation codes, mode to tile mapping and the operation function */
package alu_pkg;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_mul  = 4'd5,
        op_shl  = 4'd6,
        op_shr  = 4'd7,
        op_minu = 4'd8
    } alu_op_e;

    localparam int op_max = 8;

    // Column and row of the tile that serves an op
    function automatic noc_pkg::coord_t op_tile_x(input alu_op_e op);
        return noc_pkg::coord_t'(int'(op) % noc_pkg::mesh_dim);
    endfunction

    function automatic noc_pkg::coord_t op_tile_y(input alu_op_e op);
        return noc_pkg::coord_t'(int'(op) / noc_pkg::mesh_dim);
    endfunction

    function automatic logic [noc_pkg::data_w-1:0] alu_apply(
        input alu_op_e                    op,
        input logic [noc_pkg::data_w-1:0] a,
        input logic [noc_pkg::data_w-1:0] b
    );
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_mul:  return a * b;
            op_shl:  return a << b[5:0];
            op_shr:  return a >> b[5:0];
            op_minu: return (a < b) ? a : b;
            default: return '0;
        endcase
    endfunction

endpackage

// ==== mesh/flit_fifo.sv ====
/* Router input buffer, circular FIFO that returns one credit per pop */
`timescale 1ns/1ps

module flit_fifo #(
    parameter int fifo_depth = 2
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           push,
    input  noc_pkg::flit_t push_flit,
    input  logic           pop,
    output logic           head_valid,
    output noc_pkg::flit_t head_flit,
    output logic           credit
);
    import noc_pkg::*;

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    flit_t            mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(fifo_depth - 1)) return '0;
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= push_flit;
        end
    end

    assign head_valid = (count_q != '0);
    assign head_flit  = mem[rd_ptr_q];
    assign credit     = pop;

    // A push into a full buffer means the upstream sender ran without credit
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> count_q != cnt_w'(fifo_depth));

endmodule

// ==== mesh/noc_router.sv ====
/* Five port mesh router: input FIFOs, XY route computation, fixed priority output
   selection and per output credit counters */
`timescale 1ns/1ps

module noc_router #(
    parameter int fifo_depth = 2,
    parameter int tile_x     = 0,
    parameter int tile_y     = 0
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           in_valid   [5],
    input  noc_pkg::flit_t in_flit    [5],
    output logic           in_credit  [5],
    output logic           out_valid  [5],
    output noc_pkg::flit_t out_flit   [5],
    input  logic           out_credit [5]
);
    import noc_pkg::*;

    logic              head_valid [5];
    flit_t             head_flit  [5];
    dir_e              route      [5];
    logic [2:0]        sel        [5];
    logic [cred_w-1:0] cred_q     [5];
    logic [4:0]        pop;
    logic [4:0]        send;

    function automatic dir_e route_dir(input flit_hdr_t hdr);
        // Responses run west, then north, then out the origin's west edge
        if (hdr.resp) begin
            if (tile_x == 0 && tile_y != 0) return dir_north;
            return dir_west;
        end
        if (hdr.dst_x > tile_x) return dir_east;
        if (hdr.dst_x < tile_x) return dir_west;
        if (hdr.dst_y > tile_y) return dir_south;
        if (hdr.dst_y < tile_y) return dir_north;
        return dir_local;
    endfunction

    for (genvar i = 0; i < 5; i++) begin : g_in
        flit_fifo #(
            .fifo_depth(fifo_depth)
        ) u_fifo (
            .clk       (clk),
            .arst_n    (arst_n),
            .push      (in_valid[i]),
            .push_flit (in_flit[i]),
            .pop       (pop[i]),
            .head_valid(head_valid[i]),
            .head_flit (head_flit[i]),
            .credit    (in_credit[i])
        );

        assign route[i] = route_dir(head_flit[i].hdr);
    end

    // --------------------
    // Each output serves the first eligible head in order local, north, east, south, west
    always_comb begin
        int i;
        pop  = '0;
        send = '0;
        for (int o = 0; o < 5; o++) begin
            sel[o] = '0;
            for (int p = 0; p < 5; p++) begin
                i = (p + 4) % 5;
                if (!send[o] && cred_q[o] != '0 && head_valid[i] && route[i] == dir_e'(o)) begin
                    send[o] = 1'b1;
                    sel[o]  = 3'(i);
                end
            end
            if (send[o]) begin
                pop[sel[o]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int o = 0; o < 5; o++) begin
                out_valid[o] <= 1'b0;
                // The tile behind the local port holds a single request
                cred_q[o] <= (o == dir_local) ? cred_w'(1) : cred_w'(fifo_depth);
            end
        end else begin
            for (int o = 0; o < 5; o++) begin
                out_valid[o] <= send[o];
                cred_q[o]    <= cred_q[o] - cred_w'(send[o]) + cred_w'(out_credit[o]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < 5; o++) begin
            if (send[o]) begin
                out_flit[o] <= head_flit[sel[o]];
            end
        end
    end

    for (genvar o = 0; o < 5; o++) begin : g_chk
        localparam int cred_max = (o == dir_local) ? 1 : fifo_depth;

        a_cred_max: assert property (@(posedge clk) disable iff (!arst_n)
            cred_q[o] <= cred_max);

        // A returned credit always belongs to a flit still counted as outstanding
        a_cred_return: assert property (@(posedge clk) disable iff (!arst_n)
            out_credit[o] |-> cred_q[o] < cred_max);
    end

endmodule

// ==== verilog/tile_alu.sv ====
/* Per tile arithmetic unit, request flit in, response flit out */
`timescale 1ns/1ps

module tile_alu (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           req_valid,
    input  noc_pkg::flit_t req_flit,
    output logic           req_credit,
    output logic           rsp_valid,
    output noc_pkg::flit_t rsp_flit,
    input  logic           rsp_credit
);
    import noc_pkg::*;
    import alu_pkg::*;

    logic  rsp_pend_q;
    logic  cred_q;
    logic  send;
    flit_t rsp_next;

    always_comb begin
        rsp_next           = req_flit;
        rsp_next.hdr.resp  = 1'b1;
        rsp_next.hdr.dst_x = '0;
        rsp_next.hdr.dst_y = '0;
        // Result view overlays operand a, so read from the request copy
        rsp_next.pl.res.result = alu_apply(alu_op_e'(req_flit.hdr.op),
                                           req_flit.pl.opnd.a, req_flit.pl.opnd.b);
        rsp_next.pl.res.unused = '0;
    end

    // One response in flight toward the router's local input
    assign send       = rsp_pend_q && cred_q;
    assign rsp_valid  = send;
    assign req_credit = send;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_pend_q <= 1'b0;
            cred_q     <= 1'b1;
        end else begin
            if (req_valid) begin
                rsp_pend_q <= 1'b1;
            end else if (send) begin
                rsp_pend_q <= 1'b0;
            end
            cred_q <= rsp_credit || (cred_q && !send);
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp_flit <= rsp_next;
        end
    end

endmodule

// ==== mesh/noc_mesh.sv ====
/* 3x3 grid of routers and ALU tiles with link wiring, edge tie-offs and the host link */
`timescale 1ns/1ps

module noc_mesh #(
    parameter int fifo_depth = 2
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           inj_valid,
    input  noc_pkg::flit_t inj_flit,
    output logic           inj_credit,
    output logic           ej_valid,
    output noc_pkg::flit_t ej_flit,
    input  logic           ej_credit
);
    import noc_pkg::*;

    // Router side link signals by row, column and port
    wire        rin_valid   [mesh_dim][mesh_dim][5];
    wire flit_t rin_flit    [mesh_dim][mesh_dim][5];
    wire        rin_credit  [mesh_dim][mesh_dim][5];
    wire        rout_valid  [mesh_dim][mesh_dim][5];
    wire flit_t rout_flit   [mesh_dim][mesh_dim][5];
    wire        rout_credit [mesh_dim][mesh_dim][5];

    for (genvar y = 0; y < mesh_dim; y++) begin : g_row
        for (genvar x = 0; x < mesh_dim; x++) begin : g_col

            // --------------------
            // Neighbour links
            for (genvar d = 0; d < 4; d++) begin : g_link
                localparam int nx = x + ((d == dir_east) ? 1 : (d == dir_west) ? -1 : 0);
                localparam int ny = y + ((d == dir_south) ? 1 : (d == dir_north) ? -1 : 0);
                localparam int od = (d + 2) % 4;

                if (nx >= 0 && nx < mesh_dim && ny >= 0 && ny < mesh_dim) begin : g_nb
                    assign rin_valid[y][x][d]   = rout_valid[ny][nx][od];
                    assign rin_flit[y][x][d]    = rout_flit[ny][nx][od];
                    assign rout_credit[y][x][d] = rin_credit[ny][nx][od];
                end else if (x == 0 && y == 0 && d == dir_west) begin : g_host
                    assign rin_valid[y][x][d]   = inj_valid;
                    assign rin_flit[y][x][d]    = inj_flit;
                    assign inj_credit           = rin_credit[y][x][d];
                    assign ej_valid             = rout_valid[y][x][d];
                    assign ej_flit              = rout_flit[y][x][d];
                    assign rout_credit[y][x][d] = ej_credit;
                end else begin : g_edge
                    assign rin_valid[y][x][d]   = 1'b0;
                    assign rin_flit[y][x][d]    = '0;
                    assign rout_credit[y][x][d] = 1'b0;
                end
            end

            noc_router #(
                .fifo_depth(fifo_depth),
                .tile_x    (x),
                .tile_y    (y)
            ) u_router (
                .clk       (clk),
                .arst_n    (arst_n),
                .in_valid  (rin_valid[y][x]),
                .in_flit   (rin_flit[y][x]),
                .in_credit (rin_credit[y][x]),
                .out_valid (rout_valid[y][x]),
                .out_flit  (rout_flit[y][x]),
                .out_credit(rout_credit[y][x])
            );

            tile_alu u_alu (
                .clk       (clk),
                .arst_n    (arst_n),
                .req_valid (rout_valid[y][x][dir_local]),
                .req_flit  (rout_flit[y][x][dir_local]),
                .req_credit(rout_credit[y][x][dir_local]),
                .rsp_valid (rin_valid[y][x][dir_local]),
                .rsp_flit  (rin_flit[y][x][dir_local]),
                .rsp_credit(rin_credit[y][x][dir_local])
            );
        end
    end

endmodule

// ==== verilog/host_port.sv ====
/* Host side of the mesh: request injection with tags and credits, response capture */
`timescale 1ns/1ps

module host_port #(
    parameter int fifo_depth = 2
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic [noc_pkg::data_w-1:0]    a,
    input  logic [noc_pkg::data_w-1:0]    b,
    input  alu_pkg::alu_op_e              mode,
    output logic                          inj_valid,
    output noc_pkg::flit_t                inj_flit,
    input  logic                          inj_credit,
    input  logic                          ej_valid,
    input  noc_pkg::flit_t                ej_flit,
    output logic                          ej_credit,
    output logic [noc_pkg::data_w-1:0]    result,
    output logic [noc_pkg::tag_w-1:0]     result_tag,
    output logic                          result_valid
);
    import noc_pkg::*;
    import alu_pkg::*;

    localparam int max_out = 2 ** tag_w;

    logic [tag_w-1:0]  tag_q;
    logic [tag_w:0]    out_cnt_q;
    logic [cred_w-1:0] cred_q;
    logic              accept;
    flit_t             req_flit;

    // Ready while a tag is free and the origin's west input FIFO has room
    assign req_ready = (out_cnt_q != (tag_w + 1)'(max_out)) && (cred_q != '0);
    assign accept    = req_valid && req_ready;

    always_comb begin
        req_flit           = '0;
        req_flit.hdr.tag   = tag_q;
        req_flit.hdr.dst_x = op_tile_x(mode);
        req_flit.hdr.dst_y = op_tile_y(mode);
        req_flit.hdr.op    = mode;
        req_flit.pl.opnd.a = a;
        req_flit.pl.opnd.b = b;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inj_valid    <= 1'b0;
            tag_q        <= '0;
            out_cnt_q    <= '0;
            cred_q       <= cred_w'(fifo_depth);
            result_valid <= 1'b0;
        end else begin
            inj_valid <= accept;
            if (accept) begin
                tag_q <= tag_q + 1'b1;
            end
            out_cnt_q    <= out_cnt_q + (tag_w + 1)'(accept) - (tag_w + 1)'(result_valid);
            cred_q       <= cred_q - cred_w'(accept) + cred_w'(inj_credit);
            result_valid <= ej_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inj_flit <= req_flit;
        end
        if (ej_valid) begin
            result     <= ej_flit.pl.res.result;
            result_tag <= ej_flit.hdr.tag;
        end
    end

    // Responses are always taken and free their slot at once
    assign ej_credit = ej_valid;

    a_mode_legal: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> mode <= op_max);

    a_ej_resp: assert property (@(posedge clk) disable iff (!arst_n)
        ej_valid |-> ej_flit.hdr.resp);

endmodule

// ==== verilog/calc_top.sv ====
/* Top level of the ALU mesh calculator, host port plus 3x3 router mesh */
`timescale 1ns/1ps

module calc_top #(
    parameter int fifo_depth = 2
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic [noc_pkg::data_w-1:0]    a,
    input  logic [noc_pkg::data_w-1:0]    b,
    input  alu_pkg::alu_op_e              mode,
    output logic [noc_pkg::data_w-1:0]    result,
    output logic [noc_pkg::tag_w-1:0]     result_tag,
    output logic                          result_valid
);
    import noc_pkg::*;

    logic  inj_valid;
    flit_t inj_flit;
    logic  inj_credit;
    logic  ej_valid;
    flit_t ej_flit;
    logic  ej_credit;

    host_port #(
        .fifo_depth(fifo_depth)
    ) u_host (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .a           (a),
        .b           (b),
        .mode        (mode),
        .inj_valid   (inj_valid),
        .inj_flit    (inj_flit),
        .inj_credit  (inj_credit),
        .ej_valid    (ej_valid),
        .ej_flit     (ej_flit),
        .ej_credit   (ej_credit),
        .result      (result),
        .result_tag  (result_tag),
        .result_valid(result_valid)
    );

    noc_mesh #(
        .fifo_depth(fifo_depth)
    ) u_mesh (
        .clk       (clk),
        .arst_n    (arst_n),
        .inj_valid (inj_valid),
        .inj_flit  (inj_flit),
        .inj_credit(inj_credit),
        .ej_valid  (ej_valid),
        .ej_flit   (ej_flit),
        .ej_credit (ej_credit)
    );

endmodule

// ==== verif/calc_tb.sv ====
/* Self-checking testbench for the ALU mesh calculator, directed cases from a file,
   back to back bursts and random traffic against a reference model */
`timescale 1ns/1ps

module calc_tb;
    import noc_pkg::*;
    import alu_pkg::*;

    localparam int issue_limit = 200;
    localparam int drain_limit = 1000;

    logic              clk;
    logic              arst_n;
    logic              req_valid;
    logic              req_ready;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    alu_op_e           mode;
    logic [data_w-1:0] result;
    logic [tag_w-1:0]  result_tag;
    logic              result_valid;

    int                mismatches;
    int                failures;
    int                issue_cnt;
    int                in_flight;
    integer            seed;
    string             test_name;
    bit                pending     [8];
    logic [data_w-1:0] pend_result [8];
    string             pend_name   [8];
    logic [data_w-1:0] last_result;
    logic [tag_w-1:0]  last_tag;

    calc_top #(
        .fifo_depth(2)
    ) dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .a           (a),
        .b           (b),
        .mode        (mode),
        .result      (result),
        .result_tag  (result_tag),
        .result_valid(result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Expected result of one mode
    function automatic logic [data_w-1:0] model_result(input int m,
                                                       input logic [data_w-1:0] x,
                                                       input logic [data_w-1:0] y);
        logic [data_w-1:0] r;
        case (m)
            0: r = x + y;
            1: r = x - y;
            2: r = x & y;
            3: r = x | y;
            4: r = x ^ y;
            5: r = x * y;
            6: r = x << (y % 64);
            7: r = x >> (y % 64);
            8: begin
                if (x < y) r = x;
                else r = y;
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [data_w-1:0] expected,
                               input logic [data_w-1:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    // --------------------
    // Response monitor and outstanding count
    always @(negedge clk) begin
        if (arst_n) begin
            if (in_flight >= 8) begin
                check_value("req_ready with 8 in flight", 0, req_ready);
            end
            if (req_valid && req_ready) begin
                in_flight++;
            end
            if (result_valid) begin
                last_result = result;
                last_tag    = result_tag;
                in_flight--;
                if (!pending[result_tag]) begin
                    $display("ERROR: result with tag %0d arrived with no request in flight",
                             result_tag);
                    failures++;
                end else begin
                    check_value(pend_name[result_tag], pend_result[result_tag], result);
                    pending[result_tag] = 1'b0;
                end
            end
        end
    end

    // Called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic issue_req(input int m, input logic [data_w-1:0] x,
                             input logic [data_w-1:0] y, input logic [data_w-1:0] expected,
                             output bit accepted);
        int waited;
        int tag;
        waited   = 0;
        tag      = issue_cnt % 8;
        accepted = 1'b0;
        // A tag is reused only once its earlier request has returned
        while (pending[tag] && waited < issue_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (pending[tag]) begin
            $display("ERROR: tag %0d for %s stayed busy for %0d cycles", tag, test_name,
                     issue_limit);
            failures++;
            return;
        end
        waited    = 0;
        req_valid = 1'b1;
        mode      = alu_op_e'(m);
        a         = x;
        b         = y;
        @(negedge clk);
        while (!req_ready && waited < issue_limit) begin
            @(negedge clk);
            waited++;
        end
        accepted = req_ready;
        if (accepted) begin
            pending[tag]     = 1'b1;
            pend_result[tag] = expected;
            pend_name[tag]   = test_name;
            issue_cnt++;
        end else begin
            $display("ERROR: %s was not accepted within %0d cycles", test_name, issue_limit);
            failures++;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (in_flight != 0 && waited < drain_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (in_flight != 0) begin
            $display("ERROR: %0d requests still in flight after %0d cycles", in_flight,
                     drain_limit);
            failures++;
        end
    endtask

    // --------------------
    // Test phases
    task automatic run_directed();
        int                fd;
        int                n;
        int                code;
        int                m;
        string             line;
        logic [data_w-1:0] x;
        logic [data_w-1:0] y;
        logic [data_w-1:0] e;
        logic [tag_w-1:0]  exp_tag;
        bit                ok;
        n  = 0;
        fd = $fopen("verif/calc_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the case file verif/calc_cases.txt");
            failures++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            code = $sscanf(line, "%h %h %h %h", m, x, y, e);
            if (code != 4 || m > op_max) begin
                $display("ERROR: malformed line in the case file: %s", line);
                failures++;
                continue;
            end
            exp_tag   = tag_w'(issue_cnt % 8);
            test_name = $sformatf("case %0d mode %0d", n, m);
            issue_req(m, x, y, e, ok);
            wait_drain();
            if (ok) begin
                check_value({test_name, " tag"}, exp_tag, last_tag);
                check_value({test_name, " result"}, e, last_result);
            end
            n++;
        end
        $fclose(fd);
        if (n == 0) begin
            $display("ERROR: the case file holds no cases");
            failures++;
        end
    endtask

    // Far tiles first so the eighth accept lands before any result
    task automatic run_burst();
        int                burst_modes [8];
        logic [data_w-1:0] x;
        logic [data_w-1:0] y;
        bit                ok;
        burst_modes = '{8, 7, 5, 6, 2, 8, 4, 0};
        for (int i = 0; i < 8; i++) begin
            x         = {$random(seed), $random(seed)};
            y         = {$random(seed), $random(seed)};
            test_name = $sformatf("burst %0d mode %0d", i, burst_modes[i]);
            issue_req(burst_modes[i], x, y, model_result(burst_modes[i], x, y), ok);
        end
        // All eight tags are now in flight
        check_value("req_ready after eighth burst accept", 0, req_ready);
        wait_drain();
    endtask

    task automatic run_random();
        int                m;
        int                gap;
        logic [data_w-1:0] x;
        logic [data_w-1:0] y;
        bit                ok;
        for (int i = 0; i < 40; i++) begin
            m   = $unsigned($random(seed)) % (op_max + 1);
            x   = {$random(seed), $random(seed)};
            y   = {$random(seed), $random(seed)};
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            test_name = $sformatf("random %0d mode %0d", i, m);
            issue_req(m, x, y, model_result(m, x, y), ok);
        end
        wait_drain();
    endtask

    initial begin
        arst_n    = 1'b0;
        req_valid = 1'b0;
        a         = '0;
        b         = '0;
        mode      = op_add;
        seed      = 32'hec80;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_name = "idle after reset";
        repeat (10) begin
            @(negedge clk);
            check_value("req_ready after reset", 1, req_ready);
            check_value("result_valid after reset", 0, result_valid);
        end
        @(posedge clk);
        #1;

        run_directed();
        run_burst();
        run_random();

        for (int t = 0; t < 8; t++) begin
            if (pending[t]) begin
                $display("ERROR: tag %0d never returned a result", t);
                failures++;
            end
        end

        $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/calc_cases.txt ====
# Directed ALU cases, one per line, all fields hex
# mode a b expected_result
0 0000000000000005 0000000000000007 000000000000000c
0 ffffffffffffffff 0000000000000001 0000000000000000
0 123456789abcdef0 0fedcba987654321 2222222222222211
1 000000000000000a 0000000000000003 0000000000000007
1 0000000000000000 0000000000000001 ffffffffffffffff
1 8000000000000000 0000000000000001 7fffffffffffffff
2 ff00ff00ff00ff00 0ff00ff00ff00ff0 0f000f000f000f00
2 ffffffffffffffff 0123456789abcdef 0123456789abcdef
2 aaaaaaaaaaaaaaaa 5555555555555555 0000000000000000
3 aaaaaaaaaaaaaaaa 5555555555555555 ffffffffffffffff
3 0000000000000000 0000000000000000 0000000000000000
3 f0f0000000000000 000000000000000f f0f000000000000f
4 ffffffffffffffff 0123456789abcdef fedcba9876543210
4 1234123412341234 1234123412341234 0000000000000000
4 00000000000000ff 000000000000000f 00000000000000f0
5 0000000000000003 0000000000000007 0000000000000015
5 0000000100000000 0000000100000000 0000000000000000
5 ffffffffffffffff 0000000000000002 fffffffffffffffe
5 00000000ffffffff 00000000ffffffff fffffffe00000001
6 0000000000000001 0000000000000004 0000000000000010
6 0000000000000001 0000000000000040 0000000000000001
6 0000000000000001 000000000000003f 8000000000000000
7 8000000000000000 000000000000003f 0000000000000001
7 f000000000000000 0000000000000004 0f00000000000000
7 1234567890abcdef 0000000000000044 01234567890abcde
8 0000000000000005 0000000000000009 0000000000000005
8 ffffffffffffffff 0000000000000001 0000000000000001
8 8000000000000000 7fffffffffffffff 7fffffffffffffff

// ==== sources.f ====
common/noc_pkg.sv
common/alu_pkg.sv
mesh/flit_fifo.sv
mesh/noc_router.sv
verilog/tile_alu.sv
mesh/noc_mesh.sv
verilog/host_port.sv
verilog/calc_top.sv
verif/calc_tb.sv

// ==== Bender.yml ====
package:
  name: alu_mesh_calc

sources:
  - common/noc_pkg.sv
  - common/alu_pkg.sv
  - mesh/flit_fifo.sv
  - mesh/noc_router.sv
  - verilog/tile_alu.sv
  - mesh/noc_mesh.sv
  - verilog/host_port.sv
  - verilog/calc_top.sv
  - target: test
    files:
      - verif/calc_tb.sv
